/* Makefile */
# Verilator build, run and lint for the SoC control block

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TB_TOP    ?= tb_soc_ctrl
RTL_TOP   ?= soc_ctrl_top
FILELIST  ?= soc_ctrl_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* apb_soc_ctrl.sv */
//####################################################################
// SoC control APB register file
// Boot, cluster, direction, JTAG and status registers behind an APB
// slave. Reads are registered and take one wait state, unmapped
// words answer with PSLVERR
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "soc_ctrl_macros.svh"

module apb_soc_ctrl
   import soc_ctrl_pkg::*;
(
   input  wire                     HCLK,
   input  wire                     HRESETn,
   input  wire apb_req_t           apb_req_i,
   output apb_rsp_t                apb_rsp_o,

   input  wire                     sel_clk_i,
   input  wire                     bootsel_valid_i,
   input  wire [2:0]               bootsel_i,
   input  wire                     fc_fetch_en_valid_i,
   input  wire                     fc_fetch_en_i,
   input  wire [`SOC_JTAG_W-1:0]   soc_jtag_reg_i,
   input  wire seq_state_e         seq_state_i,

   output logic [`SOC_JTAG_W-1:0]  soc_jtag_reg_o,
   output logic [31:0]             fc_bootaddr_o,
   output logic                    fc_fetchen_o,
   output logic                    sel_hyper_axi_o,
   output logic                    sel_spi_dir_o,
   output logic                    sel_i2c_mux_o,
   output logic [63:0]             cluster_boot_addr_o,
   output logic                    cluster_irq_o,
   output cluster_req_t            cluster_req_o
);

   logic [6:0]             reg_idx;
   logic                   upper_zero;
   logic                   map_hit;
   logic [31:0]            rd_word;
   logic                   apb_access;
   logic                   apb_wr;
   logic                   rd_first;
   logic                   xfer_done;
   logic                   rd_pend_q;     // Read word captured, finish now
   logic [31:0]            rdata_q;

   logic [31:0]            r_bootaddr;
   logic                   r_fetchen;
   logic                   r_core_release;
   logic [2:0]             r_bootsel;
   logic                   r_sel_hyper_axi;
   logic                   r_sel_spi_dir;
   logic                   r_sel_i2c_mux;
   logic [31:0]            r_corestatus;
   cluster_req_t           r_cluster_req;
   logic                   r_cluster_irq;
   logic [63:0]            r_cluster_boot;
   logic [`SOC_JTAG_W-1:0] r_jtag_rego;
   logic [`SOC_JTAG_W-1:0] jtag_sync_q1;
   logic [`SOC_JTAG_W-1:0] jtag_sync_q2;

   assign reg_idx    = apb_req_i.paddr[8:2];
   assign upper_zero = (apb_req_i.paddr[`SOC_APB_ADDR_W-1:9] == '0);
   assign apb_access = apb_req_i.psel & apb_req_i.penable;

   // Writes finish in the first access cycle, reads in the second
   assign xfer_done  = apb_access & (apb_req_i.pwrite | rd_pend_q);
   assign apb_wr     = apb_access & apb_req_i.pwrite & map_hit;
   assign rd_first   = apb_access & ~apb_req_i.pwrite & ~rd_pend_q;

   assign apb_rsp_o = '{
      prdata:  rdata_q,
      pready:  xfer_done,
      pslverr: xfer_done & ~map_hit
   };

   // Word decode, shared by the read mux and the error check
   always_comb
   begin
      rd_word = '0;
      map_hit = 1'b1;
      case (reg_idx)
         `SOC_REG_INFO:           rd_word = {`SOC_NB_CORES, `SOC_NB_CLUSTERS};
         `SOC_REG_FCBOOT:         rd_word = r_bootaddr;
         `SOC_REG_FCFETCH:        rd_word = {31'h0, r_fetchen};
         `SOC_REG_CORE_RELEASE:   rd_word = {31'h0, r_core_release};
         `SOC_REG_SPI_DIR:        rd_word = {31'h0, r_sel_spi_dir};
         `SOC_REG_I2C_DIR:        rd_word = {31'h0, r_sel_i2c_mux};
         `SOC_REG_CLUSTER_CTRL:   rd_word = {28'h0, r_cluster_req};
         `SOC_REG_JTAG:
            rd_word = {{(32-2*`SOC_JTAG_W){1'b0}}, jtag_sync_q2, r_jtag_rego};
         `SOC_REG_CTRL_PER:       rd_word = {31'h0, r_sel_hyper_axi};
         `SOC_REG_CLUSTER_IRQ:    rd_word = {31'h0, r_cluster_irq};
         `SOC_REG_CL_BOOT0:       rd_word = r_cluster_boot[31:0];
         `SOC_REG_CL_BOOT1:       rd_word = r_cluster_boot[63:32];
         `SOC_REG_CORESTATUS:     rd_word = r_corestatus;
         `SOC_REG_CS_RO:          rd_word = r_corestatus;
         `SOC_REG_BOOTSEL:        rd_word = {29'h0, r_bootsel};
         `SOC_REG_CLKSEL:         rd_word = {31'h0, sel_clk_i};
         `SOC_REG_CLUSTER_STATUS: rd_word = {29'h0, seq_state_i};
         default:                 map_hit = 1'b0;
      endcase
      // Aliases above the 512 byte map are holes
      if (!upper_zero)
      begin
         map_hit = 1'b0;
         rd_word = '0;
      end
   end

   // Read word captured in the first access cycle
   always_ff @(posedge HCLK)
   begin
      if (rd_first)
         rdata_q <= rd_word;
   end

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
         rd_pend_q <= 1'b0;
      else
         rd_pend_q <= rd_first;
   end

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         r_bootaddr      <= `SOC_BOOTADDR_RST;
         r_fetchen       <= 1'b0;          // FC stays idle until told
         r_core_release  <= 1'b0;
         r_bootsel       <= 3'h0;
         r_sel_hyper_axi <= 1'b0;
         r_sel_spi_dir   <= 1'b1;          // Slave side by default
         r_sel_i2c_mux   <= 1'b1;
         r_corestatus    <= '0;
         r_cluster_req   <= '{rstn: 1'b0, fetch_en: 1'b0, pow: 1'b0, byp: 1'b1};
         r_cluster_irq   <= 1'b0;
         r_cluster_boot  <= '0;
         r_jtag_rego     <= '0;
         jtag_sync_q1    <= '0;
         jtag_sync_q2    <= '0;
      end
      else
      begin
         jtag_sync_q1 <= soc_jtag_reg_i;   // Asynchronous source
         jtag_sync_q2 <= jtag_sync_q1;

         if (apb_wr)
         begin
            case (reg_idx)
               `SOC_REG_FCBOOT:       r_bootaddr      <= apb_req_i.pwdata;
               `SOC_REG_FCFETCH:      r_fetchen       <= apb_req_i.pwdata[0];
               `SOC_REG_CORE_RELEASE: r_core_release  <= apb_req_i.pwdata[0];
               `SOC_REG_SPI_DIR:      r_sel_spi_dir   <= apb_req_i.pwdata[0];
               `SOC_REG_I2C_DIR:      r_sel_i2c_mux   <= apb_req_i.pwdata[0];
               `SOC_REG_CLUSTER_CTRL:
                  r_cluster_req <= cluster_req_t'(apb_req_i.pwdata[3:0]);
               `SOC_REG_JTAG:
                  r_jtag_rego <= apb_req_i.pwdata[`SOC_JTAG_W-1:0];
               `SOC_REG_CTRL_PER:     r_sel_hyper_axi <= apb_req_i.pwdata[0];
               `SOC_REG_CLUSTER_IRQ:  r_cluster_irq   <= apb_req_i.pwdata[0];
               `SOC_REG_CL_BOOT0:     r_cluster_boot[31:0]  <= apb_req_i.pwdata;
               `SOC_REG_CL_BOOT1:     r_cluster_boot[63:32] <= apb_req_i.pwdata;
               `SOC_REG_CORESTATUS:   r_corestatus    <= apb_req_i.pwdata;
               `SOC_REG_BOOTSEL:      r_bootsel       <= apb_req_i.pwdata[2:0];
               default:
               begin
                  // Read-only words ignore writes
               end
            endcase
         end

         // Strap inputs come last so they win over a host write
         if (fc_fetch_en_valid_i)
            r_fetchen <= fc_fetch_en_i;
         if (bootsel_valid_i)
            r_bootsel <= bootsel_i;
      end
   end

   assign soc_jtag_reg_o      = r_jtag_rego;
   assign fc_bootaddr_o       = r_bootaddr;
   assign fc_fetchen_o        = r_fetchen;
   assign sel_hyper_axi_o     = r_sel_hyper_axi;
   assign sel_spi_dir_o       = r_sel_spi_dir;
   assign sel_i2c_mux_o       = r_sel_i2c_mux;
   assign cluster_boot_addr_o = r_cluster_boot;
   assign cluster_irq_o       = r_cluster_irq;
   assign cluster_req_o       = r_cluster_req;

endmodule

`default_nettype wire

/* cluster_power_seq.sv */
//####################################################################
// Cluster power sequencer
// Turns the host's cluster requests into an ordered pin sequence.
// Up runs power, isolation release, reset release, fetch enable,
// down runs the same steps backwards
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "soc_ctrl_macros.svh"

module cluster_power_seq
   import soc_ctrl_pkg::*;
(
   input  wire                HCLK,
   input  wire                HRESETn,
   input  wire cluster_req_t  cluster_req_i,
   output cluster_pins_t      cluster_pins_o,
   output seq_state_e         seq_state_o
);

   seq_state_e    state_q;
   cluster_pins_t pins_q;
   logic [3:0]    dwell_q;       // Cycles left in the current step
   logic [3:0]    pwr_dwell;
   logic [3:0]    iso_dwell;
   logic          dwell_done;

   // Bypass shortens both waits to a single cycle
   assign pwr_dwell  = cluster_req_i.byp ? 4'd1 : `SOC_SEQ_PWR_CYC;
   assign iso_dwell  = cluster_req_i.byp ? 4'd1 : `SOC_SEQ_ISO_CYC;
   assign dwell_done = (dwell_q <= 4'd1);

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         state_q <= SEQ_OFF;
         dwell_q <= '0;
         pins_q  <= '{pow: 1'b0, iso: 1'b1, rstn: 1'b0, fetch_en: 1'b0};
      end
      else
      begin
         case (state_q)
            SEQ_OFF:
            begin
               if (cluster_req_i.pow)
               begin
                  pins_q.pow <= 1'b1;
                  dwell_q    <= pwr_dwell;
                  state_q    <= SEQ_PWR_UP;
               end
            end

            SEQ_PWR_UP:
            begin
               if (!cluster_req_i.pow)
                  state_q <= SEQ_PWR_DN;          // Still isolated, just drop power
               else if (dwell_done)
               begin
                  pins_q.iso <= 1'b0;
                  dwell_q    <= iso_dwell;
                  state_q    <= SEQ_ISO_REL;
               end
               else
                  dwell_q <= dwell_q - 4'd1;
            end

            SEQ_ISO_REL:
            begin
               if (!cluster_req_i.pow)
               begin
                  pins_q.iso <= 1'b1;
                  state_q    <= SEQ_PWR_DN;
               end
               else if (dwell_done)
                  state_q <= SEQ_ON;              // Reset now up to the host
               else
                  dwell_q <= dwell_q - 4'd1;
            end

            SEQ_ON:
            begin
               if (!cluster_req_i.pow)
               begin
                  // Stop the cores and clamp outputs before power goes
                  pins_q.fetch_en <= 1'b0;
                  pins_q.rstn     <= 1'b0;
                  pins_q.iso      <= 1'b1;
                  state_q         <= SEQ_PWR_DN;
               end
               else
               begin
                  pins_q.rstn     <= cluster_req_i.rstn;
                  pins_q.fetch_en <= cluster_req_i.fetch_en & cluster_req_i.rstn &
                                     pins_q.rstn;  // Only once reset is already out
               end
            end

            SEQ_PWR_DN:
            begin
               pins_q  <= '{pow: 1'b0, iso: 1'b1, rstn: 1'b0, fetch_en: 1'b0};
               state_q <= SEQ_OFF;
            end

            default:
            begin
               pins_q  <= '{pow: 1'b0, iso: 1'b1, rstn: 1'b0, fetch_en: 1'b0};
               state_q <= SEQ_OFF;
            end
         endcase
      end
   end

   assign cluster_pins_o = pins_q;
   assign seq_state_o    = state_q;

endmodule

`default_nettype wire

/* soc_ctrl_macros.svh */
//####################################################################
// SoC control register map and sizing
// Word indices, reset values, core counts and sequencer dwell times
//####################################################################
`ifndef SOC_CTRL_MACROS_SVH
`define SOC_CTRL_MACROS_SVH

`define SOC_APB_ADDR_W          12          // 4 KB slave window

// Word indices, taken from address bits 8 to 2
`define SOC_REG_INFO            7'h00       // Cores [31:16], clusters [15:0]
`define SOC_REG_FCBOOT          7'h01
`define SOC_REG_FCFETCH         7'h02
`define SOC_REG_CORE_RELEASE    7'h06
`define SOC_REG_SPI_DIR         7'h18       // 0 master, 1 slave
`define SOC_REG_I2C_DIR         7'h19
`define SOC_REG_CLUSTER_CTRL    7'h1C
`define SOC_REG_JTAG            7'h1D
`define SOC_REG_CTRL_PER        7'h1E
`define SOC_REG_CLUSTER_IRQ     7'h1F
`define SOC_REG_CL_BOOT0        7'h20       // Cluster boot address, low word
`define SOC_REG_CL_BOOT1        7'h21       // Cluster boot address, high word
`define SOC_REG_CORESTATUS      7'h28       // EOC in bit 31, status below
`define SOC_REG_CS_RO           7'h30       // Read-only copy of CORESTATUS
`define SOC_REG_BOOTSEL         7'h31
`define SOC_REG_CLKSEL          7'h32
`define SOC_REG_CLUSTER_STATUS  7'h33       // Sequencer state

// Reset values and sizes
`define SOC_BOOTADDR_RST        32'h1A000080
`define SOC_NB_CORES            16'd4
`define SOC_NB_CLUSTERS         16'd1
`define SOC_JTAG_W              8

// Cluster power sequencer dwell times in cycles
`define SOC_SEQ_PWR_CYC         4'd4        // Power on to isolation release
`define SOC_SEQ_ISO_CYC         4'd3        // Isolation release to reset release

`endif

/* soc_ctrl_pkg.sv */
//####################################################################
// SoC control types
// APB request and response, cluster request and pin bundles,
// and the encoding of the cluster power sequencer state
//####################################################################
`default_nettype none

`include "soc_ctrl_macros.svh"

package soc_ctrl_pkg;

   // APB master to slave
   typedef struct packed {
      logic                       psel;
      logic                       penable;
      logic                       pwrite;
      logic [`SOC_APB_ADDR_W-1:0] paddr;
      logic [31:0]                pwdata;
   } apb_req_t;

   // APB slave to master
   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;   // Only valid with pready
   } apb_rsp_t;

   // Host wishes, laid out as bits 3 to 0 of CLUSTER_CTRL
   typedef struct packed {
      logic rstn;       // Release cluster reset
      logic fetch_en;
      logic pow;
      logic byp;        // Short dwell times
   } cluster_req_t;

   // Pins seen by the cluster
   typedef struct packed {
      logic pow;
      logic iso;        // Isolation, active high
      logic rstn;
      logic fetch_en;
   } cluster_pins_t;

   // Power sequencer states
   typedef enum logic [2:0] {
      SEQ_OFF     = 3'd0,
      SEQ_PWR_UP  = 3'd1,
      SEQ_ISO_REL = 3'd2,
      SEQ_ON      = 3'd3,
      SEQ_PWR_DN  = 3'd4
   } seq_state_e;

endpackage

`default_nettype wire

/* soc_ctrl_top.f */
+incdir+.
soc_ctrl_pkg.sv
apb_soc_ctrl.sv
cluster_power_seq.sv
soc_ctrl_top.sv
tb_soc_ctrl.sv

/* soc_ctrl_top.sv */
//####################################################################
// SoC control block top level
// Packs the APB pins into structs, joins the register file to the
// cluster power sequencer and breaks the cluster pins out again
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "soc_ctrl_macros.svh"

module soc_ctrl_top
   import soc_ctrl_pkg::*;
(
   input  wire                        HCLK,
   input  wire                        HRESETn,

   // APB slave port
   input  wire                        PSEL_i,
   input  wire                        PENABLE_i,
   input  wire                        PWRITE_i,
   input  wire [`SOC_APB_ADDR_W-1:0]  PADDR_i,
   input  wire [31:0]                 PWDATA_i,
   output logic [31:0]                PRDATA_o,
   output logic                       PREADY_o,
   output logic                       PSLVERR_o,

   // Straps, JTAG and clock select
   input  wire                        sel_clk_i,
   input  wire                        bootsel_valid_i,
   input  wire [2:0]                  bootsel_i,
   input  wire                        fc_fetch_en_valid_i,
   input  wire                        fc_fetch_en_i,
   input  wire [`SOC_JTAG_W-1:0]      soc_jtag_reg_i,

   output logic [`SOC_JTAG_W-1:0]     soc_jtag_reg_o,
   output logic [31:0]                fc_bootaddr_o,
   output logic                       fc_fetchen_o,
   output logic                       sel_hyper_axi_o,
   output logic                       sel_spi_dir_o,
   output logic                       sel_i2c_mux_o,
   output logic [63:0]                cluster_boot_addr_o,
   output logic                       cluster_irq_o,

   // Cluster power pins
   output logic                       cluster_pow_o,
   output logic                       cluster_iso_o,
   output logic                       cluster_rstn_o,
   output logic                       cluster_fetch_enable_o
);

   apb_req_t      apb_req;
   apb_rsp_t      apb_rsp;
   cluster_req_t  cluster_req;
   cluster_pins_t cluster_pins;
   seq_state_e    seq_state;     // Fed back for CLUSTER_STATUS

   assign apb_req = '{
      psel:    PSEL_i,
      penable: PENABLE_i,
      pwrite:  PWRITE_i,
      paddr:   PADDR_i,
      pwdata:  PWDATA_i
   };

   assign PRDATA_o  = apb_rsp.prdata;
   assign PREADY_o  = apb_rsp.pready;
   assign PSLVERR_o = apb_rsp.pslverr;

   apb_soc_ctrl u_regs (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .apb_req_i           (apb_req),
      .apb_rsp_o           (apb_rsp),
      .sel_clk_i           (sel_clk_i),
      .bootsel_valid_i     (bootsel_valid_i),
      .bootsel_i           (bootsel_i),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .soc_jtag_reg_i      (soc_jtag_reg_i),
      .seq_state_i         (seq_state),
      .soc_jtag_reg_o      (soc_jtag_reg_o),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o),
      .sel_hyper_axi_o     (sel_hyper_axi_o),
      .sel_spi_dir_o       (sel_spi_dir_o),
      .sel_i2c_mux_o       (sel_i2c_mux_o),
      .cluster_boot_addr_o (cluster_boot_addr_o),
      .cluster_irq_o       (cluster_irq_o),
      .cluster_req_o       (cluster_req)
   );

   cluster_power_seq u_pwr_seq (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .cluster_req_i  (cluster_req),
      .cluster_pins_o (cluster_pins),
      .seq_state_o    (seq_state)
   );

   assign cluster_pow_o          = cluster_pins.pow;
   assign cluster_iso_o          = cluster_pins.iso;
   assign cluster_rstn_o         = cluster_pins.rstn;
   assign cluster_fetch_enable_o = cluster_pins.fetch_en;

endmodule

`default_nettype wire

/* tb_soc_ctrl.sv */
//####################################################################
// Testbench for the SoC control block
// Runs a stimulus table over the APB port, the strap inputs and the
// cluster power sequencer, checking read data and output pins
//####################################################################
`timescale 1ns/100ps
`default_nettype none

`include "soc_ctrl_macros.svh"

module tb_soc_ctrl
   import soc_ctrl_pkg::*;
();

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_ERR, OP_POLL, OP_DRV} op_e;

   typedef struct packed {
      op_e                          op;
      logic [`SOC_APB_ADDR_W-10:0]  page;      // Address bits above the register map
      logic [6:0]                   idx;       // Word index or drive target for OP_DRV
      logic [31:0]                  data;
      logic [31:0]                  exp;
   } entry_t;

   localparam logic [6:0] DRV_CLK     = 7'd0;
   localparam logic [6:0] DRV_BOOTSEL = 7'd1;
   localparam logic [6:0] DRV_FETCH   = 7'd2;
   localparam logic [6:0] DRV_JTAG    = 7'd3;
   localparam int         POLL_MAX    = 12;
   localparam logic [`SOC_JTAG_W-1:0] JTAG_IN_VAL = 'h5A;

   localparam cluster_pins_t PINS_OFF = '{pow: 1'b0, iso: 1'b1, rstn: 1'b0, fetch_en: 1'b0};
   localparam cluster_pins_t PINS_HELD = '{pow: 1'b1, iso: 1'b0, rstn: 1'b0, fetch_en: 1'b0};
   localparam cluster_pins_t PINS_RUN = '{pow: 1'b1, iso: 1'b0, rstn: 1'b1, fetch_en: 1'b1};

   logic hclk, hresetn, psel, penable, pwrite, pready, pslverr;
   logic [`SOC_APB_ADDR_W-1:0] paddr;
   logic [31:0] pwdata, prdata, fc_bootaddr;
   logic sel_clk, bootsel_valid, fetch_en_valid, fetch_en;
   logic [2:0] bootsel;
   logic [`SOC_JTAG_W-1:0] jtag_in, jtag_out;
   logic fc_fetchen, sel_hyper_axi, sel_spi_dir, sel_i2c_mux, cluster_irq;
   logic [63:0] cl_boot;
   logic cl_pow, cl_iso, cl_rstn, cl_fetch;

   entry_t      tbl[$];
   logic [31:0] lfsr;
   logic        table_ready = 1'b0;

   soc_ctrl_top DUT (
      .HCLK (hclk), .HRESETn (hresetn),
      .PSEL_i (psel), .PENABLE_i (penable), .PWRITE_i (pwrite),
      .PADDR_i (paddr), .PWDATA_i (pwdata),
      .PRDATA_o (prdata), .PREADY_o (pready), .PSLVERR_o (pslverr),
      .sel_clk_i (sel_clk), .bootsel_valid_i (bootsel_valid), .bootsel_i (bootsel),
      .fc_fetch_en_valid_i (fetch_en_valid), .fc_fetch_en_i (fetch_en),
      .soc_jtag_reg_i (jtag_in), .soc_jtag_reg_o (jtag_out),
      .fc_bootaddr_o (fc_bootaddr), .fc_fetchen_o (fc_fetchen),
      .sel_hyper_axi_o (sel_hyper_axi), .sel_spi_dir_o (sel_spi_dir),
      .sel_i2c_mux_o (sel_i2c_mux), .cluster_boot_addr_o (cl_boot),
      .cluster_irq_o (cluster_irq),
      .cluster_pow_o (cl_pow), .cluster_iso_o (cl_iso),
      .cluster_rstn_o (cl_rstn), .cluster_fetch_enable_o (cl_fetch)
   );

   initial
   begin
      hclk = 1'b0;
      forever #10 hclk = ~hclk;
   end

   task stop_with_failure();
      $display("Something failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp)
      begin
         $display("FAIL %s: got %08h, expected %08h", name, act, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_pins(input string name, input cluster_pins_t act,
                             input cluster_pins_t exp);
      if (act !== exp)
      begin
         $display("FAIL %s: got %h, expected %h", name, act, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_state(input string name, input seq_state_e act, input seq_state_e exp);
      if (act !== exp)
      begin
         $display("FAIL %s: got %h, expected %h", name, act, exp);
         stop_with_failure();
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] word;
      logic        fb;
      word = '0;
      for (int i = 0; i < nbits; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         word = {word[30:0], fb};
      end
      return word;
   endfunction

   function automatic cluster_pins_t current_pins();
      return '{pow: cl_pow, iso: cl_iso, rstn: cl_rstn, fetch_en: cl_fetch};
   endfunction

   task automatic add_entry(input op_e op, input logic [6:0] idx, input logic [31:0] data,
                            input logic [31:0] exp);
      tbl.push_back('{op, {(`SOC_APB_ADDR_W-9){1'b0}}, idx, data, exp});
   endtask

   // Mapped word reached through an alias above the register map
   task automatic add_alias_error(input logic [6:0] idx, input logic [31:0] data);
      tbl.push_back('{OP_ERR, {{(`SOC_APB_ADDR_W-10){1'b0}}, 1'b1}, idx, data, 32'h0});
   endtask

   // One APB transfer that returns 2 ns after the completing edge
   task automatic apb_xfer(input logic wr, input logic [`SOC_APB_ADDR_W-10:0] page,
                           input logic [6:0] idx, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic slverr);
      @(posedge hclk);
      #2;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = {page, idx, 2'b00};
      pwdata  = wdata;
      @(posedge hclk);
      #2;
      penable = 1'b1;
      @(negedge hclk);
      while (!pready)
         @(negedge hclk);
      rdata  = prdata;   // Stable half a cycle before the edge
      slverr = pslverr;
      @(posedge hclk);
      #2;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic drive_input(input logic [6:0] target, input logic [31:0] value);
      @(posedge hclk);
      #2;
      case (target)
         DRV_CLK:  sel_clk = value[0];
         DRV_JTAG: jtag_in = value[`SOC_JTAG_W-1:0];   // Held until changed
         DRV_BOOTSEL:
         begin
            bootsel       = value[2:0];
            bootsel_valid = 1'b1;
         end
         DRV_FETCH:
         begin
            fetch_en       = value[0];
            fetch_en_valid = 1'b1;
         end
         default:
         begin
            $display("Unknown drive target %0d in the stimulus table", target);
            stop_with_failure();
         end
      endcase
      @(posedge hclk);
      #2;
      bootsel_valid  = 1'b0;
      fetch_en_valid = 1'b0;
   endtask

   // Checks the output pin that mirrors a register if there is one
   task automatic verify_output_pin(input logic [6:0] idx, input logic [31:0] exp);
      case (idx)
         `SOC_REG_FCBOOT:      check_word("fc_bootaddr_o", fc_bootaddr, exp);
         `SOC_REG_FCFETCH:     check_word("fc_fetchen_o", {31'h0, fc_fetchen}, exp);
         `SOC_REG_SPI_DIR:     check_word("sel_spi_dir_o", {31'h0, sel_spi_dir}, exp);
         `SOC_REG_I2C_DIR:     check_word("sel_i2c_mux_o", {31'h0, sel_i2c_mux}, exp);
         `SOC_REG_CTRL_PER:    check_word("sel_hyper_axi_o", {31'h0, sel_hyper_axi}, exp);
         `SOC_REG_CLUSTER_IRQ: check_word("cluster_irq_o", {31'h0, cluster_irq}, exp);
         `SOC_REG_CL_BOOT0:    check_word("cluster_boot_addr_o[31:0]", cl_boot[31:0], exp);
         `SOC_REG_CL_BOOT1:    check_word("cluster_boot_addr_o[63:32]", cl_boot[63:32], exp);
         `SOC_REG_JTAG:
            check_word("soc_jtag_reg_o", {{(32-`SOC_JTAG_W){1'b0}}, jtag_out},
                       {{(32-`SOC_JTAG_W){1'b0}}, exp[`SOC_JTAG_W-1:0]});
         default: ;
      endcase
   endtask

   task automatic poll_status(input seq_state_e target, input cluster_pins_t pins);
      logic [31:0]   rd;
      logic          err;
      int            n;
      cluster_pins_t act;
      n = 0;
      apb_xfer(1'b0, '0, `SOC_REG_CLUSTER_STATUS, 32'h0, rd, err);
      while (seq_state_e'(rd[2:0]) != target && n < POLL_MAX)
      begin
         act     = current_pins();
         act.iso = 1'b0;          // Isolation release falls inside the wait
         if (target == SEQ_ON)    // Powered and still in reset without fetch
            check_pins("cluster pins during power-up", act, PINS_HELD);
         apb_xfer(1'b0, '0, `SOC_REG_CLUSTER_STATUS, 32'h0, rd, err);
         n++;
      end
      if (seq_state_e'(rd[2:0]) != target)
      begin
         $display("Cluster status did not reach %s within %0d polls", target.name(), POLL_MAX);
         stop_with_failure();
      end
      check_word("PSLVERR", {31'h0, err}, 32'h0);
      check_state("CLUSTER_STATUS", seq_state_e'(rd[2:0]), target);
      check_pins("cluster pins", current_pins(), pins);
   endtask

   task automatic run_entry(input entry_t e);
      logic [31:0] rd;
      logic        err;
      case (e.op)
         OP_WR, OP_RD:
         begin
            if (e.op == OP_WR)
            begin
               apb_xfer(1'b1, e.page, e.idx, e.data, rd, err);
               check_word($sformatf("PSLVERR write %02h", e.idx), {31'h0, err}, 32'h0);
            end
            apb_xfer(1'b0, e.page, e.idx, 32'h0, rd, err);
            check_word($sformatf("PSLVERR read %02h", e.idx), {31'h0, err}, 32'h0);
            check_word($sformatf("PRDATA %02h", e.idx), rd, e.exp);
            verify_output_pin(e.idx, e.exp);
         end
         OP_ERR:
         begin
            apb_xfer(1'b1, e.page, e.idx, e.data, rd, err);
            check_word($sformatf("PSLVERR write %02h", e.idx), {31'h0, err}, 32'h1);
            apb_xfer(1'b0, e.page, e.idx, 32'h0, rd, err);
            check_word($sformatf("PSLVERR read %02h", e.idx), {31'h0, err}, 32'h1);
            check_word($sformatf("PRDATA %02h", e.idx), rd, 32'h0);
         end
         OP_POLL: poll_status(seq_state_e'(e.exp[2:0]), cluster_pins_t'(e.data[3:0]));
         default: drive_input(e.idx, e.data);
      endcase
   endtask

   task automatic build_table();
      logic [31:0] w;
      logic [31:0] boot_w;
      // Reset state
      add_entry(OP_RD, `SOC_REG_INFO, 0, {`SOC_NB_CORES, `SOC_NB_CLUSTERS});
      add_entry(OP_RD, `SOC_REG_FCBOOT, 0, `SOC_BOOTADDR_RST);
      add_entry(OP_RD, `SOC_REG_SPI_DIR, 0, 32'h1);
      add_entry(OP_RD, `SOC_REG_I2C_DIR, 0, 32'h1);
      add_entry(OP_RD, `SOC_REG_FCFETCH, 0, 32'h0);
      add_entry(OP_RD, `SOC_REG_CLUSTER_IRQ, 0, 32'h0);
      add_entry(OP_RD, `SOC_REG_CLUSTER_CTRL, 0, 32'h1);   // Bypass only
      add_entry(OP_POLL, 0, {28'h0, PINS_OFF}, {29'h0, SEQ_OFF});
      // Writable registers with LFSR scratch words
      boot_w = rand_bits(32);
      add_entry(OP_WR, `SOC_REG_FCBOOT, boot_w, boot_w);
      w = rand_bits(32);
      add_entry(OP_WR, `SOC_REG_CL_BOOT0, w, w);
      w = rand_bits(32);
      add_entry(OP_WR, `SOC_REG_CL_BOOT1, w, w);
      w = rand_bits(32);
      add_entry(OP_WR, `SOC_REG_CORESTATUS, w, w);
      add_entry(OP_RD, `SOC_REG_CS_RO, 0, w);
      add_entry(OP_WR, `SOC_REG_FCFETCH, 32'hFFFF_FFFF, 32'h1);
      add_entry(OP_WR, `SOC_REG_CORE_RELEASE, 32'h1, 32'h1);
      add_entry(OP_WR, `SOC_REG_SPI_DIR, 32'hFFFF_FFF0, 32'h0);
      add_entry(OP_WR, `SOC_REG_I2C_DIR, 32'h0, 32'h0);
      add_entry(OP_WR, `SOC_REG_CTRL_PER, 32'h1, 32'h1);
      add_entry(OP_WR, `SOC_REG_CLUSTER_IRQ, 32'h1, 32'h1);
      add_entry(OP_WR, `SOC_REG_BOOTSEL, 32'hFFFF_FFFD, 32'h5);
      // Holes in the map
      add_entry(OP_ERR, 7'h05, rand_bits(32), 0);
      add_entry(OP_ERR, 7'h7F, rand_bits(32), 0);
      add_alias_error(`SOC_REG_FCBOOT, ~boot_w);
      add_entry(OP_RD, `SOC_REG_FCBOOT, 0, boot_w);
      // Straps, JTAG and clock select
      add_entry(OP_DRV, DRV_BOOTSEL, 32'h3, 0);
      add_entry(OP_RD, `SOC_REG_BOOTSEL, 0, 32'h3);
      add_entry(OP_DRV, DRV_FETCH, 32'h0, 0);
      add_entry(OP_RD, `SOC_REG_FCFETCH, 0, 32'h0);
      add_entry(OP_DRV, DRV_CLK, 32'h1, 0);
      add_entry(OP_RD, `SOC_REG_CLKSEL, 0, 32'h1);
      add_entry(OP_DRV, DRV_JTAG, {{(32-`SOC_JTAG_W){1'b0}}, JTAG_IN_VAL}, 0);
      w = rand_bits(`SOC_JTAG_W);
      add_entry(OP_WR, `SOC_REG_JTAG, w,
                {{(32-2*`SOC_JTAG_W){1'b0}}, JTAG_IN_VAL, w[`SOC_JTAG_W-1:0]});
      // CLUSTER_CTRL bits are rstn, fetch_en, pow, byp
      add_entry(OP_WR, `SOC_REG_CLUSTER_CTRL, 32'h2, 32'h2);
      add_entry(OP_POLL, 0, {28'h0, PINS_HELD}, {29'h0, SEQ_ON});
      add_entry(OP_WR, `SOC_REG_CLUSTER_CTRL, 32'hE, 32'hE);
      add_entry(OP_POLL, 0, {28'h0, PINS_RUN}, {29'h0, SEQ_ON});
      add_entry(OP_WR, `SOC_REG_CLUSTER_CTRL, 32'h6, 32'h6);   // Fetch alone is not enough
      add_entry(OP_POLL, 0, {28'h0, PINS_HELD}, {29'h0, SEQ_ON});
      add_entry(OP_WR, `SOC_REG_CLUSTER_CTRL, 32'h0, 32'h0);
      add_entry(OP_POLL, 0, {28'h0, PINS_OFF}, {29'h0, SEQ_OFF});
      add_entry(OP_WR, `SOC_REG_CLUSTER_CTRL, 32'h3, 32'h3);
      add_entry(OP_POLL, 0, {28'h0, PINS_HELD}, {29'h0, SEQ_ON});
      add_entry(OP_WR, `SOC_REG_CLUSTER_CTRL, 32'h1, 32'h1);
      add_entry(OP_POLL, 0, {28'h0, PINS_OFF}, {29'h0, SEQ_OFF});
   endtask

   initial
   begin
      int limit;
      wait (table_ready);
      limit = 5 + 40 * tbl.size() + 4 * (`SOC_SEQ_PWR_CYC + `SOC_SEQ_ISO_CYC);
      repeat (limit) @(posedge hclk);
      $display("Watchdog expired after %0d cycles, the run hung", limit);
      stop_with_failure();
   end

   initial
   begin
      hresetn = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      sel_clk = 1'b0;
      bootsel_valid = 1'b0;
      bootsel = 3'h0;
      fetch_en_valid = 1'b0;
      fetch_en = 1'b0;
      jtag_in = '0;
      lfsr = 32'd20;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge hclk);
      #2;
      hresetn = 1'b1;
      foreach (tbl[i])
         run_entry(tbl[i]);
      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire
